//--- panel.f
rtl/panel_pkg.sv
rtl/sseg_decode.sv
rtl/panel_regs.sv
rtl/indicators.sv
rtl/panel_top.sv
dv/panel_checker.sv
dv/panel_tb.sv

//--- dv/panel_tb.sv
/*
 * front panel testbench
 * clock, reset, stimulus table and watchdog around panel_top
 */

`timescale 1ns/1ns

module panel_tb;

  typedef struct packed {
    panel_pkg::panel_op_e op;
    logic [6:0]           data;
    logic                 valid;
    panel_pkg::activity_t act;
    logic [8*12-1:0]      name;
  } row_t;

  logic                          clk = 1'b0;
  logic                          rst;
  panel_pkg::panel_wr_t          wr;
  logic                          wr_valid;
  panel_pkg::activity_t          act;
  logic [panel_pkg::sseg_w-1:0]  hex_0, hex_1, hex_2, hex_3;
  logic [panel_pkg::led_g_w-1:0] led_g;
  logic [panel_pkg::led_r_w-1:0] led_r;
  int                            row;
  logic [8*12-1:0]               name;
  int                            pass_cnt, fail_cnt, err_cnt;
  row_t                          rows [$];
  row_t                          cur;   // row being driven
  integer                        seed;
  logic [31:0]                   rnd;
  logic                          table_ready;

  always #2 clk = ~clk;

  panel_top i_dut (
    .clk (clk), .rst (rst), .wr (wr), .wr_valid (wr_valid), .act (act),
    .hex_0 (hex_0), .hex_1 (hex_1), .hex_2 (hex_2), .hex_3 (hex_3),
    .led_g (led_g), .led_r (led_r)
  );

  panel_checker u_chk (
    .clk (clk), .rst (rst), .wr (wr), .wr_valid (wr_valid), .act (act),
    .row (row), .name (name),
    .hex_0 (hex_0), .hex_1 (hex_1), .hex_2 (hex_2), .hex_3 (hex_3),
    .led_g (led_g), .led_r (led_r),
    .pass_cnt (pass_cnt), .fail_cnt (fail_cnt), .err_cnt (err_cnt)
  );

  task automatic add_row(input panel_pkg::panel_op_e op, input logic [6:0] data,
                         input logic valid, input logic [3:0] a, input logic [8*12-1:0] nm);
    row_t r;
    r.op    = op;
    r.data  = data;
    r.valid = valid;
    r.act   = a;
    r.name  = nm;
    rows.push_back(r);
  endtask

  task automatic build_table();
    add_row(panel_pkg::op_none, 7'h00, 1'b0, 4'b0000, "reset_zero");
    for (int d = 0; d < 16; d++) begin
      add_row(panel_pkg::op_volume, {d[2:0], d[3:0]}, 1'b1, 4'b0000, "vol_digits");
    end
    repeat (3) begin
      rnd = $random(seed);
      add_row(panel_pkg::op_volume, rnd[6:0], 1'b1, 4'b0000, "vol_random");
    end
    for (int d = 15; d >= 0; d--) begin   // volume digits must hold through these
      add_row(panel_pkg::op_track, {d[2:0], d[3:0]}, 1'b1, 4'b0000, "trk_digits");
    end
    repeat (3) begin
      rnd = $random(seed);
      add_row(panel_pkg::op_track, rnd[6:0], 1'b1, 4'b0000, "trk_random");
    end
    add_row(panel_pkg::op_status, 7'h05, 1'b1, 4'b0000, "status");
    add_row(panel_pkg::op_status, 7'h7a, 1'b1, 4'b0000, "status_trunc");
    add_row(panel_pkg::op_none, 7'h33, 1'b1, 4'b0000, "op_none");
    add_row(panel_pkg::op_volume, 7'h55, 1'b0, 4'b0000, "valid_low");
    add_row(panel_pkg::op_status, 7'h07, 1'b0, 4'b0000, "valid_low");
    // one pulse per channel, then a back to back burst on all four
    add_row(panel_pkg::op_none, 7'h00, 1'b0, 4'b1000, "act_f_wr");
    repeat (2) add_row(panel_pkg::op_none, 7'h00, 1'b0, 4'b0000, "act_idle");
    add_row(panel_pkg::op_none, 7'h00, 1'b0, 4'b0100, "act_f_rd");
    repeat (2) add_row(panel_pkg::op_none, 7'h00, 1'b0, 4'b0000, "act_idle");
    add_row(panel_pkg::op_none, 7'h00, 1'b0, 4'b0010, "act_h_wr");
    repeat (2) add_row(panel_pkg::op_none, 7'h00, 1'b0, 4'b0000, "act_idle");
    add_row(panel_pkg::op_none, 7'h00, 1'b0, 4'b0001, "act_h_rd");
    repeat (2) add_row(panel_pkg::op_none, 7'h00, 1'b0, 4'b0000, "act_idle");
    repeat (3) add_row(panel_pkg::op_none, 7'h00, 1'b0, 4'b1111, "act_b2b");
    repeat (3) add_row(panel_pkg::op_none, 7'h00, 1'b0, 4'b0000, "act_idle");
  endtask

  initial begin
    rst = 1'b1;
    wr = '0;
    wr_valid = 1'b0;
    act = '0;
    row = -1;
    name = '0;
    table_ready = 1'b0;
    seed = 32'hd520;
    build_table();
    table_ready = 1'b1;
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
    foreach (rows[i]) begin
      @(posedge clk);
      #1;
      cur      = rows[i];
      wr.op    = cur.op;
      wr.data  = cur.data;
      wr_valid = cur.valid;
      act      = cur.act;
      row      = i;
      name     = cur.name;
    end
    @(posedge clk);
    #1;
    wr_valid = 1'b0;
    act = '0;
    row = -1;
    wait (pass_cnt + fail_cnt == rows.size());
    $display("tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // watchdog, table length plus reset and drain margin
  initial begin
    wait (table_ready);
    #((rows.size() + 20) * 4);
    $display("timeout: the run did not finish after %0d table rows", rows.size());
    $display("Some tests failed");
    $finish;
  end

endmodule

//--- dv/panel_checker.sv
/*
 * front panel checker
 * reference model of registers, digits and led stretch, compared every cycle
 */

`timescale 1ns/1ns

module panel_checker (
  input  logic                          clk,
  input  logic                          rst,
  input  panel_pkg::panel_wr_t          wr,
  input  logic                          wr_valid,
  input  panel_pkg::activity_t          act,
  input  int                            row,    // -1 when no table row is driven
  input  logic [8*12-1:0]               name,
  input  logic [panel_pkg::sseg_w-1:0]  hex_0,
  input  logic [panel_pkg::sseg_w-1:0]  hex_1,
  input  logic [panel_pkg::sseg_w-1:0]  hex_2,
  input  logic [panel_pkg::sseg_w-1:0]  hex_3,
  input  logic [panel_pkg::led_g_w-1:0] led_g,
  input  logic [panel_pkg::led_r_w-1:0] led_r,
  output int                            pass_cnt,
  output int                            fail_cnt,
  output int                            err_cnt
);

  logic [panel_pkg::value_w-1:0]  vol_m;
  logic [panel_pkg::value_w-1:0]  trk_m;
  logic [panel_pkg::status_w-1:0] sts_m;
  logic [panel_pkg::sseg_w-1:0]   hex_m [4];   // 0,1 track  2,3 volume
  int                             cnt_m [4];   // cycles left, indexed like act
  logic [3:0]                     act_v;
  int                             row_p1;
  int                             row_p2;
  logic [8*12-1:0]                name_p1;
  logic [8*12-1:0]                name_p2;
  int                             cyc_errs;
  logic [panel_pkg::led_g_w-1:0]  led_g_m;
  logic [panel_pkg::led_r_w-1:0]  led_r_m;

  // common anode pattern, gfedcba, low lights a segment
  function automatic logic [6:0] seg_of(input logic [3:0] d);
    case (d)
      4'h0: return 7'b1000000;
      4'h1: return 7'b1111001;
      4'h2: return 7'b0100100;
      4'h3: return 7'b0110000;
      4'h4: return 7'b0011001;
      4'h5: return 7'b0010010;
      4'h6: return 7'b0000010;
      4'h7: return 7'b1111000;
      4'h8: return 7'b0000000;
      4'h9: return 7'b0010000;
      4'ha: return 7'b0001000;
      4'hb: return 7'b0000011;
      4'hc: return 7'b1000110;
      4'hd: return 7'b0100001;
      4'he: return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  task automatic compare(input logic [8*6-1:0] what, input logic [9:0] got,
                         input logic [9:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %0s mismatch, got %h expected %h", $time, what, got, exp);
      cyc_errs++;
      err_cnt++;
    end
  endtask

  initial begin
    pass_cnt = 0;
    fail_cnt = 0;
    err_cnt  = 0;
  end

  assign act_v = act;

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      vol_m  <= '0;
      trk_m  <= '0;
      sts_m  <= '0;
      row_p1 <= -1;
      row_p2 <= -1;
      for (int i = 0; i < 4; i++) begin
        hex_m[i] <= panel_pkg::sseg_blank;
        cnt_m[i] <= 0;
      end
    end else begin
      if (wr_valid && wr.op == panel_pkg::op_volume) vol_m <= wr.data;
      if (wr_valid && wr.op == panel_pkg::op_track)  trk_m <= wr.data;
      if (wr_valid && wr.op == panel_pkg::op_status) sts_m <= wr.data[2:0];
      // digits follow the registers one edge later
      hex_m[0] <= seg_of(trk_m[3:0]);
      hex_m[1] <= seg_of({1'b0, trk_m[6:4]});
      hex_m[2] <= seg_of(vol_m[3:0]);
      hex_m[3] <= seg_of({1'b0, vol_m[6:4]});
      for (int i = 0; i < 4; i++) begin
        if (act_v[i]) begin
          cnt_m[i] <= panel_pkg::stretch_len;   // retrigger
        end else if (cnt_m[i] != 0) begin
          cnt_m[i] <= cnt_m[i] - 1;
        end
      end
      row_p1  <= row;
      name_p1 <= name;
      row_p2  <= row_p1;
      name_p2 <= name_p1;
    end
  end

  // act bits: 3 f_wr, 2 f_rd, 1 h_wr, 0 h_rd
  assign led_g_m = {{(panel_pkg::led_g_w - 2){1'b0}}, cnt_m[0] != 0, cnt_m[2] != 0};
  assign led_r_m = {sts_m, {(panel_pkg::led_r_w - panel_pkg::status_w - 2){1'b0}},
                    cnt_m[1] != 0, cnt_m[3] != 0};

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    cyc_errs = 0;
    compare("hex_0", hex_0, hex_m[0]);
    compare("hex_1", hex_1, hex_m[1]);
    compare("hex_2", hex_2, hex_m[2]);
    compare("hex_3", hex_3, hex_m[3]);
    compare("led_g", led_g, led_g_m);
    compare("led_r", led_r, led_r_m);
    if (row_p2 >= 0) begin   // this row's write has reached the digits
      if (cyc_errs == 0) begin
        pass_cnt++;
        $display("test %0d %0s: pass", row_p2, name_p2);
      end else begin
        fail_cnt++;
        $display("test %0d %0s: FAIL with %0d errors", row_p2, name_p2, cyc_errs);
      end
    end
  end

endmodule

//--- rtl/panel_top.sv
/*
 * front panel top
 * host register block feeding the hex digits and leds
 */

`timescale 1ns/1ns

module panel_top (
  input  logic                          clk,
  input  logic                          rst,
  input  panel_pkg::panel_wr_t          wr,
  input  logic                          wr_valid,
  input  panel_pkg::activity_t          act,
  output logic [panel_pkg::sseg_w-1:0]  hex_0,
  output logic [panel_pkg::sseg_w-1:0]  hex_1,
  output logic [panel_pkg::sseg_w-1:0]  hex_2,
  output logic [panel_pkg::sseg_w-1:0]  hex_3,
  output logic [panel_pkg::led_g_w-1:0] led_g,
  output logic [panel_pkg::led_r_w-1:0] led_r
);

  panel_pkg::panel_state_t state;   // registered volume, track, status

  panel_regs u_regs (
    .clk      (clk),
    .rst      (rst),
    .wr       (wr),
    .wr_valid (wr_valid),
    .state    (state)
  );

  // hex lags a write by two edges, status leds by one
  indicators u_ind (
    .clk   (clk),
    .rst   (rst),
    .state (state),
    .act   (act),
    .hex_0 (hex_0),
    .hex_1 (hex_1),
    .hex_2 (hex_2),
    .hex_3 (hex_3),
    .led_g (led_g),
    .led_r (led_r)
  );

endmodule

//--- rtl/indicators.sv
/*
 * front panel indicators
 * hex digits for track and volume, stretched disk activity and status leds
 */

`timescale 1ns/1ns

module indicators (
  input  logic                          clk,
  input  logic                          rst,
  input  panel_pkg::panel_state_t       state,
  input  panel_pkg::activity_t          act,     // single cycle pulses
  output logic [panel_pkg::sseg_w-1:0]  hex_0,   // track low digit
  output logic [panel_pkg::sseg_w-1:0]  hex_1,   // track high digit
  output logic [panel_pkg::sseg_w-1:0]  hex_2,   // volume low digit
  output logic [panel_pkg::sseg_w-1:0]  hex_3,   // volume high digit
  output logic [panel_pkg::led_g_w-1:0] led_g,
  output logic [panel_pkg::led_r_w-1:0] led_r
);

  localparam int n_act = $bits(panel_pkg::activity_t);
  localparam int sl    = panel_pkg::stretch_len;

  logic [3:0] track_lo;
  logic [3:0] track_hi;
  logic [3:0] volume_lo;
  logic [3:0] volume_hi;

  logic [n_act-1:0]  act_bits;
  logic [sl-1:0]     stretch_q [n_act];
  logic [n_act-1:0]  lit_bits;
  panel_pkg::activity_t lit;

  // 7 bit values, so the high digit tops out at 7
  assign track_lo  = state.track[3:0];
  assign track_hi  = {1'b0, state.track[panel_pkg::value_w-1:4]};
  assign volume_lo = state.volume[3:0];
  assign volume_hi = {1'b0, state.volume[panel_pkg::value_w-1:4]};

  sseg_decode u_hex_0 (
    .clk  (clk),
    .rst  (rst),
    .num  (track_lo),
    .sseg (hex_0)
  );

  sseg_decode u_hex_1 (
    .clk  (clk),
    .rst  (rst),
    .num  (track_hi),
    .sseg (hex_1)
  );

  sseg_decode u_hex_2 (
    .clk  (clk),
    .rst  (rst),
    .num  (volume_lo),
    .sseg (hex_2)
  );

  sseg_decode u_hex_3 (
    .clk  (clk),
    .rst  (rst),
    .num  (volume_hi),
    .sseg (hex_3)
  );

  // activity stretch, a new pulse refills the shift register
  assign act_bits = act;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < n_act; i++) begin
        stretch_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < n_act; i++) begin
        stretch_q[i] <= {stretch_q[i][sl-2:0], act_bits[i]};
      end
    end
  end

  always_comb begin
    for (int i = 0; i < n_act; i++) begin
      lit_bits[i] = |stretch_q[i];
    end
  end

  assign lit = lit_bits;

  // reads on green, writes on red
  assign led_g = {{(panel_pkg::led_g_w - 2){1'b0}}, lit.h_rd, lit.f_rd};
  assign led_r = {state.status,                                  // top red leds, unregistered
                  {(panel_pkg::led_r_w - panel_pkg::status_w - 2){1'b0}},
                  lit.h_wr, lit.f_wr};

endmodule

//--- rtl/panel_regs.sv
/*
 * panel control block
 * decodes strobed host writes into the volume, track and status registers
 */

`timescale 1ns/1ns

module panel_regs (
  input  logic                    clk,
  input  logic                    rst,
  input  panel_pkg::panel_wr_t    wr,
  input  logic                    wr_valid,   // single cycle, always accepted
  output panel_pkg::panel_state_t state
);

  panel_pkg::panel_state_t state_d;

  logic wr_volume;
  logic wr_track;
  logic wr_status;

  // one write enable per register
  always_comb begin
    wr_volume = 1'b0;
    wr_track  = 1'b0;
    wr_status = 1'b0;
    if (wr_valid) begin
      case (wr.op)
        panel_pkg::op_volume: wr_volume = 1'b1;
        panel_pkg::op_track:  wr_track  = 1'b1;
        panel_pkg::op_status: wr_status = 1'b1;
        default: ;                               // op_none
      endcase
    end
  end

  always_comb begin
    state_d = state;
    if (wr_volume) begin
      state_d.volume = wr.data;
    end
    if (wr_track) begin
      state_d.track = wr.data;
    end
    if (wr_status) begin
      state_d.status = wr.data[panel_pkg::status_w-1:0];   // upper data bits dropped
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= '0;
    end else begin
      state <= state_d;
    end
  end

endmodule

//--- rtl/sseg_decode.sv
/*
 * seven segment decoder
 * hex digit to registered, active low segments (bit 0 is segment a)
 */

`timescale 1ns/1ns

module sseg_decode (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [3:0]                   num,   // hex digit
  output logic [panel_pkg::sseg_w-1:0] sseg   // active low
);

  logic [panel_pkg::sseg_w-1:0] seg_on;   // active high, gfedcba

  always_comb begin
    case (num)
      4'h0:    seg_on = 7'h3f;
      4'h1:    seg_on = 7'h06;
      4'h2:    seg_on = 7'h5b;
      4'h3:    seg_on = 7'h4f;
      4'h4:    seg_on = 7'h66;
      4'h5:    seg_on = 7'h6d;
      4'h6:    seg_on = 7'h7d;
      4'h7:    seg_on = 7'h07;
      4'h8:    seg_on = 7'h7f;
      4'h9:    seg_on = 7'h6f;
      4'ha:    seg_on = 7'h77;
      4'hb:    seg_on = 7'h7c;   // lower case b
      4'hc:    seg_on = 7'h39;
      4'hd:    seg_on = 7'h5e;   // lower case d
      4'he:    seg_on = 7'h79;
      default: seg_on = 7'h71;   // f
    endcase
  end

  // board segments are driven low to light
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sseg <= panel_pkg::sseg_blank;
    end else begin
      sseg <= ~seg_on;
    end
  end

endmodule

//--- rtl/panel_pkg.sv
/*
 * front panel package
 * widths, host opcodes and the structs shared by the indicator subsystem
 */

package panel_pkg;

  // register widths
  localparam int value_w  = 7;   // volume and track
  localparam int status_w = 3;   // control block status

  // display and leds
  localparam int sseg_w      = 7;
  localparam int stretch_len = 2;                  // led on-time in cycles
  localparam logic [sseg_w-1:0] sseg_blank = '1;   // active low, all segments off
  localparam int led_g_w     = 8;
  localparam int led_r_w     = 10;

  // host write opcodes
  typedef enum logic [1:0] {
    op_none   = 2'd0,
    op_volume = 2'd1,
    op_track  = 2'd2,
    op_status = 2'd3
  } panel_op_e;

  // one host write, qualified by wr_valid
  typedef struct packed {
    panel_op_e          op;
    logic [value_w-1:0] data;
  } panel_wr_t;

  // register block contents
  typedef struct packed {
    logic [value_w-1:0]  volume;
    logic [value_w-1:0]  track;    // floppy track number
    logic [status_w-1:0] status;
  } panel_state_t;

  // disk fifo activity strobes
  typedef struct packed {
    logic f_wr;   // floppy write
    logic f_rd;   // floppy read
    logic h_wr;   // harddisk write
    logic h_rd;   // harddisk read
  } activity_t;

endpackage
